// ==== hdl/record_pkg.sv ====
package record_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Processed record layout, as it sits in one processing FIFO word
    ////////////////////////////////////////////////////////////////////////////
    localparam int PROC_W      = 108;   // Full FIFO word
    localparam int COUNT_W     = 10;    // FIFO data count
    localparam int PARAM_A_W   = 16;
    localparam int PARAM_C_W   = 8;
    localparam int ERR_W       = 20;    // Signed error, carried as raw bits
    localparam int TS_W        = 64;    // Free running timestamp

    // Field positions, timestamp in the low bits
    localparam int TS_LSB      = 0;
    localparam int ERR_LSB     = TS_LSB + TS_W;         // 64
    localparam int PARAM_C_LSB = ERR_LSB + ERR_W;       // 84
    localparam int PARAM_A_LSB = PARAM_C_LSB + PARAM_C_W; // 92

    typedef logic [PROC_W-1:0]    proc_word_t;
    typedef logic [COUNT_W-1:0]   fifo_count_t;
    typedef logic [PARAM_A_W-1:0] param_a_t;
    typedef logic [PARAM_C_W-1:0] param_c_t;
    typedef logic [ERR_W-1:0]     err_t;
    typedef logic [TS_W-1:0]      time_stamp_t;

    // Reader FSM
    typedef enum logic [1:0] {
        rd_idle,        // Wait for data in the processing FIFO
        rd_read,        // Read strobe is out
        rd_wait_data,   // FIFO output settles, captured at the end of this state
        rd_hold         // Record held until the serializer takes it
    } reader_state_t;

endpackage

// ==== hdl/packet_pkg.sv ====
package packet_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // SD card packet layout
    ////////////////////////////////////////////////////////////////////////////
    localparam int BYTE_W    = 8;
    localparam int IDX_W     = 4;       // Enough for a 16 byte packet
    localparam int PKT_BYTES = 16;      // Token, channel, 14 payload bytes

    typedef logic [BYTE_W-1:0] pkt_byte_t;
    typedef logic [IDX_W-1:0]  byte_index_t;

    // Start token, marks the first byte of every packet
    localparam pkt_byte_t BARKER_CODE = 8'hF1;

    // Single detector channel for now
    localparam pkt_byte_t CHANNEL_ID  = 8'd1;

    // Last valid index, used for the end of packet check
    localparam byte_index_t LAST_IDX  = byte_index_t'(PKT_BYTES - 1);

    // Serializer FSM
    // One byte costs present -> strobe -> release, so at least 3 cycles
    typedef enum logic [1:0] {
        ser_idle,       // Wait for a held record
        ser_present,    // Put next byte on sd_din once the SD FIFO has room
        ser_strobe,     // Write enable high for this cycle only
        ser_release     // Write enable low again, decide next byte or done
    } ser_state_t;

endpackage

// ==== hdl/record_if.sv ====
// One held record between the reader and the serializer
// rec_valid is a level, rec_take a single cycle pulse
interface record_if import record_pkg::*; ();

    param_a_t    param_a;
    param_c_t    param_c;
    err_t        err;
    time_stamp_t time_stamp;
    logic        rec_valid;     // High while fields are held and stable
    logic        rec_take;      // Serializer has loaded the fields

    modport reader (
        output param_a,
        output param_c,
        output err,
        output time_stamp,
        output rec_valid,
        input  rec_take
    );

    modport serializer (
        input  param_a,
        input  param_c,
        input  err,
        input  time_stamp,
        input  rec_valid,
        output rec_take
    );

endinterface

// ==== hdl/record_reader.sv ====
module record_reader import record_pkg::*; (
    input  logic        clk210_p,
    input  logic        reset_p,
    input  fifo_count_t fifo_data_count,
    input  proc_word_t  fifo_dout,
    output logic        fifo_rd_en,
    record_if.reader    rec
);

    reader_state_t state;

    ////////////////////////////////////////////////////////////////////////////
    // Read control
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk210_p) begin
        if (reset_p) begin
            state         <= rd_idle;
            fifo_rd_en    <= 1'b0;
            rec.rec_valid <= 1'b0;
        end else begin
            case (state)
                rd_idle: begin
                    // Only fetch when nothing is held, one word per strobe
                    if (!rec.rec_valid && fifo_data_count != '0) begin
                        fifo_rd_en <= 1'b1;
                        state      <= rd_read;
                    end
                end

                rd_read: begin
                    fifo_rd_en <= 1'b0;         // Single cycle strobe
                    state      <= rd_wait_data;
                end

                // FIFO output valid one cycle after the read
                rd_wait_data: begin
                    rec.rec_valid <= 1'b1;      // Fields land at the same edge
                    state         <= rd_hold;
                end

                rd_hold: begin
                    if (rec.rec_take) begin
                        rec.rec_valid <= 1'b0;  // Serializer has its own copy now
                        state         <= rd_idle;
                    end
                end

                default: begin
                    fifo_rd_en <= 1'b0;
                    state      <= rd_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Field capture
    ////////////////////////////////////////////////////////////////////////////
    // Word is {param_a, param_c, err, time_stamp}
    always_ff @(posedge clk210_p) begin
        if (state == rd_wait_data) begin
            rec.param_a    <= fifo_dout[PARAM_A_LSB +: PARAM_A_W];  // 107:92
            rec.param_c    <= fifo_dout[PARAM_C_LSB +: PARAM_C_W];  // 91:84
            rec.err        <= fifo_dout[ERR_LSB +: ERR_W];          // 83:64
            rec.time_stamp <= fifo_dout[TS_LSB +: TS_W];            // 63:0
        end
    end

endmodule

// ==== hdl/byte_serializer.sv ====
module byte_serializer import packet_pkg::*; (
    input  logic         clk210_p,
    input  logic         reset_p,
    record_if.serializer rec,
    output pkt_byte_t    sd_din,
    output logic         sd_wr_en,
    input  logic         sd_full
);

    ser_state_t  state;
    byte_index_t idx;                   // Next byte to present
    logic        last_byte;             // Byte on sd_din closes the packet
    logic        load;
    pkt_byte_t   pkt_buf [PKT_BYTES];   // Framed packet, byte 0 goes out first

    assign load = (state == ser_idle) && rec.rec_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Packet buffer
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk210_p) begin
        if (load) begin
            pkt_buf[0] <= BARKER_CODE;              // Start token
            pkt_buf[1] <= CHANNEL_ID;
            pkt_buf[2] <= rec.param_a[15:8];        // param_a, MSB first
            pkt_buf[3] <= rec.param_a[7:0];
            pkt_buf[4] <= rec.param_c;
            pkt_buf[5] <= {4'h0, rec.err[19:16]};   // Top err nibble, zero padded
            pkt_buf[6] <= rec.err[15:8];
            pkt_buf[7] <= rec.err[7:0];
            // Timestamp fills the last eight bytes, MSB first
            for (int i = 0; i < 8; i++) begin
                pkt_buf[8 + i] <= rec.time_stamp[63 - 8*i -: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Byte stepping and SD FIFO write strobe
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk210_p) begin
        if (reset_p) begin
            state        <= ser_idle;
            idx          <= '0;
            last_byte    <= 1'b0;
            sd_din       <= '0;
            sd_wr_en     <= 1'b0;
            rec.rec_take <= 1'b0;
        end else begin
            rec.rec_take <= 1'b0;   // Pulse only
            case (state)
                ser_idle: begin
                    if (load) begin
                        rec.rec_take <= 1'b1;   // Reader may prefetch after this
                        idx          <= '0;
                        state        <= ser_present;
                    end
                end

                ser_present: begin
                    // Full SD FIFO just holds us here, index untouched
                    if (!sd_full) begin
                        sd_din    <= pkt_buf[idx];
                        sd_wr_en  <= 1'b1;
                        last_byte <= (idx == LAST_IDX);
                        idx       <= idx + 1'b1;    // Wraps to 0 after byte 15
                        state     <= ser_strobe;
                    end
                end

                ser_strobe: begin
                    sd_wr_en <= 1'b0;   // Written at this edge, one cycle high
                    state    <= ser_release;
                end

                ser_release: begin
                    if (last_byte) begin
                        state <= ser_idle;      // Whole packet out
                    end else begin
                        state <= ser_present;
                    end
                end

                default: begin
                    sd_wr_en <= 1'b0;
                    state    <= ser_idle;
                end
            endcase
        end
    end

endmodule

// ==== hdl/data_packetizer.sv ====
// Processed records to SD card write FIFO, 16 byte packets
module data_packetizer import record_pkg::*, packet_pkg::*; (
    input  logic        clk210_p,
    input  logic        reset_p,

    // Processing FIFO side
    output logic        fifo_rd_en,
    input  fifo_count_t fifo_data_count,
    input  proc_word_t  fifo_dout,

    // SD card write FIFO side
    output pkt_byte_t   sd_din,
    output logic        sd_wr_en,
    input  logic        sd_full
);

    ////////////////////////////////////////////////////////////////////////////
    // Held record between the two stages
    ////////////////////////////////////////////////////////////////////////////
    record_if rec_i ();

    // Stage 1, fetch and hold one record
    record_reader record_reader_i (
        .clk210_p        (clk210_p),
        .reset_p         (reset_p),
        .fifo_data_count (fifo_data_count),
        .fifo_dout       (fifo_dout),
        .fifo_rd_en      (fifo_rd_en),
        .rec             (rec_i.reader)
    );

    // Stage 2, frame and write byte by byte
    byte_serializer byte_serializer_i (
        .clk210_p (clk210_p),
        .reset_p  (reset_p),
        .rec      (rec_i.serializer),
        .sd_din   (sd_din),
        .sd_wr_en (sd_wr_en),
        .sd_full  (sd_full)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk210_p,
    output logic reset_p
);

    localparam int HALF_PERIOD  = 4;    // Period 8
    localparam int RESET_CYCLES = 3;

    initial begin
        clk210_p = 1'b0;
        forever #HALF_PERIOD clk210_p = ~clk210_p;
    end

    initial begin
        reset_p = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk210_p);
        #1 reset_p = 1'b0;              // Released just after an edge, like the other inputs
    end

endmodule

// ==== verif/data_packetizer_sva.sv ====
module data_packetizer_sva import packet_pkg::*; (
    input logic      clk210_p,
    input logic      reset_p,
    input logic      fifo_rd_en,
    input pkt_byte_t sd_din,
    input logic      sd_wr_en
);

    int fail_count = 0;     // Read by the testbench at the end of the run

    ////////////////////////////////////////////////////////////////////////////
    // Handshake rules on the two FIFO sides
    ////////////////////////////////////////////////////////////////////////////
    // Both strobes low right after reset
    reset_quiet: assert property (@(posedge clk210_p)
        reset_p |=> (!fifo_rd_en && !sd_wr_en))
        else begin
            fail_count++;
            $error("fifo_rd_en or sd_wr_en high in the cycle after reset");
        end

    // Processing FIFO read is a single cycle pulse
    rd_single: assert property (@(posedge clk210_p) disable iff (reset_p)
        fifo_rd_en |=> !fifo_rd_en)
        else begin
            fail_count++;
            $error("fifo_rd_en high for more than one cycle");
        end

    // SD write strobe never back to back
    wr_single: assert property (@(posedge clk210_p) disable iff (reset_p)
        sd_wr_en |=> !sd_wr_en)
        else begin
            fail_count++;
            $error("sd_wr_en high in two consecutive cycles");
        end

    wr_data_stable: assert property (@(posedge clk210_p) disable iff (reset_p)
        sd_wr_en |=> $stable(sd_din))   // Byte must not move under the strobe
        else begin
            fail_count++;
            $error("sd_din changed while sd_wr_en was high");
        end

endmodule

bind data_packetizer data_packetizer_sva data_packetizer_sva_i (.*);

// ==== verif/data_packetizer_tb.sv ====
module data_packetizer_tb import record_pkg::*, packet_pkg::*; ();

    typedef struct packed {
        param_a_t    param_a;
        param_c_t    param_c;
        err_t        err;
        time_stamp_t time_stamp;
        logic [15:0] full_pat;          // sd_full per cycle with bit 0 first
    } rec_entry_t;

    localparam int NUM_REC     = 6;
    localparam int TOTAL_BYTES = NUM_REC * PKT_BYTES;
    localparam int MAX_STALL   = 8;     // Longest full run in the table plus random extra
    localparam int PRE_IDLE    = 10;
    localparam int POST_IDLE   = 20;
    localparam int TIMEOUT     = NUM_REC * PKT_BYTES * (3 + MAX_STALL) + 50
                                 + PRE_IDLE + POST_IDLE;

    rec_entry_t rec_table [NUM_REC] = '{
        '{16'h1234, 8'h56, 20'h9ABCD, 64'h0123_4567_89AB_CDEF, 16'h0000},
        '{16'hFFFF, 8'h00, 20'hFFFFF, 64'hFFFF_FFFF_FFFF_FFFF, 16'h00F0},  // 4 cycle stall
        '{16'h0001, 8'h80, 20'h10000, 64'h8000_0000_0000_0001, 16'h5555},
        '{16'hA5A5, 8'h5A, 20'h0F00F, 64'hDEAD_BEEF_0BAD_F00D, 16'h03E0},  // 5 cycle stall
        '{16'h0000, 8'hFF, 20'h00001, 64'h0000_0000_0000_0000, 16'h8001},
        '{16'hC0DE, 8'h3C, 20'h7FFFF, 64'h0011_2233_4455_6677, 16'h0000}
    };

    logic        clk210_p;
    logic        reset_p;
    logic        fifo_rd_en;
    fifo_count_t fifo_data_count;
    proc_word_t  fifo_dout;
    pkt_byte_t   sd_din;
    logic        sd_wr_en;
    logic        sd_full;

    proc_word_t  fifo_q [$];            // Processing FIFO contents
    pkt_byte_t   exp_q [$];             // Bytes still to come out
    int          n_pushed   = 0;
    int          n_popped   = 0;
    int          n_bytes    = 0;
    int          n_rd       = 0;        // fifo_rd_en pulses seen
    int          value_errs = 0;
    int          other_errs = 0;
    int          cycles     = 0;
    int          seed;

    assign fifo_data_count = fifo_count_t'(n_pushed - n_popped);

    tb_clock_gen tb_clock_gen_i (.clk210_p(clk210_p), .reset_p(reset_p));

    data_packetizer data_packetizer_i (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Processing FIFO model with data one cycle after the read
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk210_p) begin : fifo_model
        if (fifo_rd_en) begin
            @(posedge clk210_p);        // FIFO takes the read at this edge
            #1;
            if (fifo_q.size() == 0) begin
                $display("read strobe while the processing FIFO model was empty");
                other_errs++;
            end else begin
                fifo_dout = fifo_q.pop_front();
                n_popped++;
            end
        end
    end

    // Record into the FIFO and its packet into the expected queue
    task automatic push_record(input rec_entry_t e);
        fifo_q.push_back({e.param_a, e.param_c, e.err, e.time_stamp});
        n_pushed++;
        exp_q.push_back(BARKER_CODE);
        exp_q.push_back(CHANNEL_ID);
        exp_q.push_back(e.param_a[15:8]);
        exp_q.push_back(e.param_a[7:0]);
        exp_q.push_back(e.param_c);
        exp_q.push_back({4'h0, e.err[19:16]});      // Zero padded top nibble
        exp_q.push_back(e.err[15:8]);
        exp_q.push_back(e.err[7:0]);
        for (int i = 7; i >= 0; i--) begin
            exp_q.push_back(e.time_stamp[8*i +: 8]);    // MSB first
        end
    endtask

    task automatic check_quiet(input int ncyc, input string phase);
        repeat (ncyc) begin
            @(negedge clk210_p);
            if (fifo_rd_en !== 1'b0 || sd_wr_en !== 1'b0) begin
                $display("error: fifo_rd_en=%h sd_wr_en=%h expected 0 %s",
                         fifo_rd_en, sd_wr_en, phase);
                value_errs++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output monitor sampled mid cycle
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk210_p) begin : monitor
        pkt_byte_t exp_b;
        if (!reset_p && fifo_rd_en) begin
            n_rd++;
        end
        if (!reset_p && sd_wr_en) begin
            if (exp_q.size() == 0) begin
                $display("unexpected write strobe, no byte left to compare");
                other_errs++;
            end else begin
                exp_b = exp_q.pop_front();
                if (sd_din !== exp_b) begin
                    $display("error: sd_din packet %0d byte %0d expected %h got %h",
                             n_bytes / PKT_BYTES, n_bytes % PKT_BYTES, exp_b, sd_din);
                    value_errs++;
                end
            end
            if (n_bytes == PKT_BYTES - 1 && n_rd < 2) begin   // Prefetch of record 1
                $display("second record not fetched before the first packet ended");
                other_errs++;
            end
            n_bytes++;
        end
    end

    always @(posedge clk210_p) begin : watchdog
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, %0d of %0d bytes written",
                     cycles, n_bytes, TOTAL_BYTES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial begin : stimulus
        int unsigned extra;
        int          sva_errs;
        sd_full   = 1'b0;
        fifo_dout = '0;
        seed      = 32'hc1a5c03f;
        @(negedge reset_p);             // Reset released just after an edge
        if (sd_din !== '0) begin
            $display("error: sd_din after reset expected 00 got %h", sd_din);
            value_errs++;
        end
        check_quiet(PRE_IDLE, "with an empty processing FIFO");
        @(posedge clk210_p);
        #1;
        for (int r = 0; r < NUM_REC; r++) begin
            push_record(rec_table[r]);
            for (int b = 0; b < PKT_BYTES; b++) begin
                sd_full = rec_table[r].full_pat[b];
                @(posedge clk210_p);
                #1;
            end
            extra = $unsigned($random(seed)) % 4;   // Random extra stall
            repeat (extra) begin
                sd_full = 1'b1;
                @(posedge clk210_p);
                #1;
            end
            sd_full = 1'b0;
        end
        while (n_bytes < TOTAL_BYTES) begin
            @(posedge clk210_p);
        end
        check_quiet(POST_IDLE, "after the last packet");
        if (n_rd != NUM_REC) begin
            $display("saw %0d processing FIFO reads for %0d records", n_rd, NUM_REC);
            other_errs++;
        end
        sva_errs = data_packetizer_i.data_packetizer_sva_i.fail_count;
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errs, other_errs, sva_errs);
        if (value_errs == 0 && other_errs == 0 && sva_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hdl/record_pkg.sv
hdl/packet_pkg.sv
hdl/record_if.sv
hdl/record_reader.sv
hdl/byte_serializer.sv
hdl/data_packetizer.sv
verif/tb_clock_gen.sv
verif/data_packetizer_sva.sv
verif/data_packetizer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the data_packetizer testbench with Verilator
LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -f all.f --top-module data_packetizer_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vdata_packetizer_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
